// File: build.f
+incdir+.
i2s_pkg.sv
i2s_ctrl_regs.sv
i2s_frame_gen.sv
i2s_tx.sv
i2s_rx.sv
i2s_port.sv
tb_i2s_checker.sv
tb_i2s_port.sv

// File: i2s_consts.svh
/* word length, frame length and default test pattern for the I2S port */

`ifndef I2S_CONSTS_SVH
`define I2S_CONSTS_SVH

// bits per channel, MSB first on the wire
`define I2S_WORD_BITS 16

// bit clocks per CLRCLK period
// left half then right half
`define I2S_FRAME_BITS 32

// reset value of both pattern registers
`define I2S_DEF_PATTERN 16'h8F50

`endif

// File: i2s_ctrl_regs.sv
/* write-only control registers: enable, source select, left/right test pattern */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module i2s_ctrl_regs
	import i2s_pkg::*;
(
	input  logic                      CBCLK,
	input  logic                      rst_n,
	input  logic                      cfg_we,		// write strobe, no ack
	input  reg_addr_t                 cfg_addr,
	input  logic [`I2S_WORD_BITS-1:0] cfg_wdata,
	output logic                      enable,
	output logic                      pattern_sel,	// 1 sends the pattern words
	output logic [`I2S_WORD_BITS-1:0] pat_left,
	output logic [`I2S_WORD_BITS-1:0] pat_right
);

	// control bits
	always_ff @(posedge CBCLK) begin
		if (!rst_n) begin
			enable      <= 1'b0;	// port idles after reset
			pattern_sel <= 1'b0;
		end else if (cfg_we && cfg_addr == REG_CTRL) begin
			enable      <= cfg_wdata[0];
			pattern_sel <= cfg_wdata[1];	// upper bits ignored
		end
	end

	// pattern words come up as the fixed test value
	always_ff @(posedge CBCLK) begin
		if (!rst_n) begin
			pat_left  <= `I2S_DEF_PATTERN;
			pat_right <= `I2S_DEF_PATTERN;
		end else if (cfg_we) begin
			case (cfg_addr)
				REG_PAT_L: pat_left  <= cfg_wdata;
				REG_PAT_R: pat_right <= cfg_wdata;
				default: ;	// REG_CTRL handled above
			endcase
		end
	end

	// host may only write mapped addresses
	a_cfg_addr_known: assert property (
		@(posedge CBCLK) disable iff (!rst_n)
		cfg_we |-> cfg_addr inside {REG_CTRL, REG_PAT_L, REG_PAT_R}
	) else $error("write to unmapped register address %0d", cfg_addr);

endmodule

// File: i2s_frame_gen.sv
/* frame bit counter, makes CLRCLK and the frame_start strobe */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module i2s_frame_gen (
	input  logic CBCLK,
	input  logic rst_n,
	input  logic enable,
	output logic clrclk,		// low = left, high = right
	output logic frame_start	// last bit clock of the frame
);

	localparam int CNT_W = $clog2(`I2S_FRAME_BITS);
	localparam logic [CNT_W-1:0] HALF = CNT_W'(`I2S_WORD_BITS);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`I2S_FRAME_BITS - 1);

	logic [CNT_W-1:0] bit_cnt;

	// count 0..31 while enabled
	// parked at 0 so the first enabled cycle is count 0
	always_ff @(posedge CBCLK) begin
		if (!rst_n) begin
			bit_cnt <= '0;
		end else if (!enable) begin
			bit_cnt <= '0;
		end else if (bit_cnt == LAST) begin
			bit_cnt <= '0;
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// CLRCLK idles high
	// left half is counts 0..15
	assign clrclk = enable ? (bit_cnt >= HALF) : 1'b1;

	// tx latches its next pair here
	assign frame_start = enable && (bit_cnt == LAST);

	// while running, CLRCLK may only flip at the half boundaries
	a_clr_toggle: assert property (
		@(posedge CBCLK) disable iff (!rst_n)
		enable && $past(enable) && (clrclk != $past(clrclk))
			|-> (bit_cnt == '0) || (bit_cnt == HALF)
	) else $error("CLRCLK toggled at count %0d", bit_cnt);

endmodule

// File: i2s_pkg.sv
/* shared types for the I2S port: register map and FSM state encodings */

package i2s_pkg;

	// register map of the config port
	typedef enum logic [1:0] {
		REG_CTRL  = 2'd0,	// bit0 enable, bit1 pattern_sel
		REG_PAT_L = 2'd1,	// left test pattern word
		REG_PAT_R = 2'd2	// right test pattern word
	} reg_addr_t;

	// receiver FSM, follows CLRCLK edges on its own
	typedef enum logic [2:0] {
		RX_WAIT_HIGH  = 3'd0,
		RX_WAIT_LOW   = 3'd1,
		RX_LEFT       = 3'd2,
		RX_WAIT_RIGHT = 3'd3,
		RX_RIGHT      = 3'd4
	} rx_state_t;

	// transmitter FSM
	typedef enum logic {
		TX_IDLE = 1'b0,
		TX_RUN  = 1'b1
	} tx_state_t;

endpackage

// File: i2s_port.sv
/* I2S port top: control registers, frame generator, transmitter, receiver */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module i2s_port
	import i2s_pkg::*;
(
	input  logic                      CBCLK,	// codec bit clock, only clock
	input  logic                      rst_n,
	input  logic                      cfg_we,
	input  reg_addr_t                 cfg_addr,
	input  logic [`I2S_WORD_BITS-1:0] cfg_wdata,
	input  logic [`I2S_WORD_BITS-1:0] tx_left,
	input  logic [`I2S_WORD_BITS-1:0] tx_right,
	input  logic                      sdin,
	output logic                      clrclk,
	output logic                      sdout,
	output logic                      tx_load,
	output logic [`I2S_WORD_BITS-1:0] rx_left,
	output logic [`I2S_WORD_BITS-1:0] rx_right,
	output logic                      rx_valid
);

	logic                      enable;
	logic                      pattern_sel;
	logic [`I2S_WORD_BITS-1:0] pat_left;
	logic [`I2S_WORD_BITS-1:0] pat_right;
	logic                      frame_start;

	i2s_ctrl_regs regs0 (
		.CBCLK       (CBCLK),
		.rst_n       (rst_n),
		.cfg_we      (cfg_we),
		.cfg_addr    (cfg_addr),
		.cfg_wdata   (cfg_wdata),
		.enable      (enable),
		.pattern_sel (pattern_sel),
		.pat_left    (pat_left),
		.pat_right   (pat_right)
	);

	i2s_frame_gen fgen0 (
		.CBCLK       (CBCLK),
		.rst_n       (rst_n),
		.enable      (enable),
		.clrclk      (clrclk),
		.frame_start (frame_start)
	);

	i2s_tx tx0 (
		.CBCLK       (CBCLK),
		.rst_n       (rst_n),
		.frame_start (frame_start),
		.pattern_sel (pattern_sel),
		.pat_left    (pat_left),
		.pat_right   (pat_right),
		.tx_left     (tx_left),
		.tx_right    (tx_right),
		.sdout       (sdout),
		.tx_load     (tx_load)
	);

	// rx sees only CLRCLK, not the frame counter
	i2s_rx rx0 (
		.CBCLK    (CBCLK),
		.rst_n    (rst_n),
		.enable   (enable),
		.clrclk   (clrclk),
		.sdin     (sdin),
		.rx_left  (rx_left),
		.rx_right (rx_right),
		.rx_valid (rx_valid)
	);

endmodule

// File: i2s_rx.sv
/* receiver FSM, tracks CLRCLK edges and deserializes left/right ADC words */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module i2s_rx
	import i2s_pkg::*;
(
	input  logic                      CBCLK,
	input  logic                      rst_n,
	input  logic                      enable,
	input  logic                      clrclk,
	input  logic                      sdin,		// serial data from codec ADC
	output logic [`I2S_WORD_BITS-1:0] rx_left,
	output logic [`I2S_WORD_BITS-1:0] rx_right,
	output logic                      rx_valid	// one pulse per pair
);

	localparam int W     = `I2S_WORD_BITS;
	localparam int BIT_W = $clog2(`I2S_WORD_BITS);
	localparam logic [BIT_W-1:0] LAST = BIT_W'(`I2S_WORD_BITS - 1);

	rx_state_t        state;
	logic [BIT_W-1:0] bit_cnt;	// bits still to take, counts down
	logic [W-1:0]     shreg;
	logic [W-1:0]     word_in;	// word including the bit on sdin now
	logic             last_left;
	logic             last_right;

	// free-running input shifter
	assign word_in = {shreg[W-2:0], sdin};

	always_ff @(posedge CBCLK) begin
		shreg <= word_in;
	end

	assign last_left  = (state == RX_LEFT)  && (bit_cnt == '0);
	assign last_right = (state == RX_RIGHT) && (bit_cnt == '0);

	// the edge that first sees a new CLRCLK level samples the delay bit
	always_ff @(posedge CBCLK) begin
		if (!rst_n) begin
			state    <= RX_WAIT_HIGH;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else if (!enable) begin
			state    <= RX_WAIT_HIGH;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_valid <= last_right;
			case (state)
				RX_WAIT_HIGH: if (clrclk) state <= RX_WAIT_LOW;
				RX_WAIT_LOW: begin
					if (!clrclk) begin	// delay bit, skip it
						state   <= RX_LEFT;
						bit_cnt <= LAST;
					end
				end
				RX_LEFT: begin
					if (bit_cnt != '0) begin
						bit_cnt <= bit_cnt - 1'b1;
					end else if (clrclk) begin	// left LSB sits in the right delay slot
						state   <= RX_RIGHT;
						bit_cnt <= LAST;
					end else begin
						state <= RX_WAIT_RIGHT;
					end
				end
				RX_WAIT_RIGHT: begin
					if (clrclk) begin
						state   <= RX_RIGHT;
						bit_cnt <= LAST;
					end
				end
				RX_RIGHT: begin
					if (bit_cnt != '0) begin
						bit_cnt <= bit_cnt - 1'b1;
					end else if (!clrclk) begin	// next left frame follows directly
						state   <= RX_LEFT;
						bit_cnt <= LAST;
					end else begin
						state <= RX_WAIT_LOW;
					end
				end
				default: state <= RX_WAIT_HIGH;
			endcase
		end
	end

	// words hold until the next capture
	always_ff @(posedge CBCLK) begin
		if (enable && last_left)  rx_left  <= word_in;
		if (enable && last_right) rx_right <= word_in;
	end

	a_valid_pulse: assert property (
		@(posedge CBCLK) disable iff (!rst_n)
		rx_valid |=> !rx_valid
	) else $error("rx_valid high for two cycles");

endmodule

// File: i2s_tx.sv
/* transmit sample latch and 33-bit shifter with the I2S one-bit delay */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module i2s_tx
	import i2s_pkg::*;
(
	input  logic                      CBCLK,
	input  logic                      rst_n,
	input  logic                      frame_start,
	input  logic                      pattern_sel,
	input  logic [`I2S_WORD_BITS-1:0] pat_left,
	input  logic [`I2S_WORD_BITS-1:0] pat_right,
	input  logic [`I2S_WORD_BITS-1:0] tx_left,
	input  logic [`I2S_WORD_BITS-1:0] tx_right,
	output logic                      sdout,	// serial data to codec DAC
	output logic                      tx_load	// tx_left/tx_right taken
);

	localparam int W     = `I2S_WORD_BITS;
	localparam int CNT_W = $clog2(`I2S_FRAME_BITS);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`I2S_FRAME_BITS - 1);

	tx_state_t        state;
	logic [2*W:0]     shreg;	// top bit is the delay slot
	logic [2*W-1:0]   sample;
	logic [CNT_W-1:0] bit_cnt;	// bits shifted since the last load

	// source chosen at the strobe
	assign sample = pattern_sel ? {pat_left, pat_right} : {tx_left, tx_right};

	always_ff @(posedge CBCLK) begin
		if (!rst_n) begin
			state   <= TX_IDLE;
			shreg   <= '0;
			bit_cnt <= '0;
		end else if (frame_start) begin
			state   <= TX_RUN;
			// old right LSB goes out in the delay slot
			shreg   <= {shreg[2*W-1], sample};
			bit_cnt <= '0;
		end else if (state == TX_RUN) begin
			bit_cnt <= bit_cnt + 1'b1;
			if (bit_cnt == LAST) begin	// strobe missed, generator stopped
				state <= TX_IDLE;
				shreg <= '0;
			end else begin
				shreg <= {shreg[2*W-1:0], 1'b0};	// MSB first
			end
		end
	end

	assign sdout   = shreg[2*W];
	assign tx_load = frame_start;	// host sees the sampling instant

	a_load_only_on_start: assert property (
		@(posedge CBCLK) disable iff (!rst_n)
		tx_load |-> frame_start
	) else $error("tx_load without frame_start");

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the I2S port testbench with Verilator, run it, judge the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_i2s_port -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -qx "Test OK" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tb_i2s_checker.sv
/* testbench checker: frame timing model, sdout word rebuild, rx pair compare */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module tb_i2s_checker
	import i2s_pkg::*;
(
	input  logic                      CBCLK,
	input  logic                      rst_n,
	input  logic                      cfg_we,
	input  reg_addr_t                 cfg_addr,
	input  logic [`I2S_WORD_BITS-1:0] cfg_wdata,
	input  logic [`I2S_WORD_BITS-1:0] tx_left,
	input  logic [`I2S_WORD_BITS-1:0] tx_right,
	input  logic                      clrclk,
	input  logic                      sdout,
	input  logic                      tx_load,
	input  logic [`I2S_WORD_BITS-1:0] rx_left,
	input  logic [`I2S_WORD_BITS-1:0] rx_right,
	input  logic                      rx_valid,
	input  logic                      codec_push,	// codec just put the last right bit out
	input  logic [`I2S_WORD_BITS-1:0] codec_left,
	input  logic [`I2S_WORD_BITS-1:0] codec_right,
	output int                        mism_cnt,
	output int                        tx_words,
	output int                        rx_pairs
);

	localparam int W  = `I2S_WORD_BITS;
	localparam int FB = `I2S_FRAME_BITS;

	logic           known = 1'b0;	// set once a reset was seen
	logic           ever_en, en, psel, rx_due;
	logic [W-1:0]   pat_l, pat_r;
	logic [W-1:0]   rl, rr;		// words rebuilt from sdout
	int             cnt;		// expected frame bit count
	int             n_mism = 0;
	int             n_tx = 0;
	int             n_rx = 0;
	logic [2*W-1:0] txq[$];		// pairs latched at frame_start
	logic [2*W-1:0] rxq[$];		// pairs sent by the codec

	assign mism_cnt = n_mism;
	assign tx_words = n_tx;
	assign rx_pairs = n_rx;

	task automatic report_mismatch(input string msg);
		n_mism++;
		$display("Mismatch at %0t ns: %s", $time, msg);
	endtask

	// negedge sampling, everything is settled here
	always @(negedge CBCLK) begin
		logic           exp_clr;
		logic           exp_fs;
		logic [2*W-1:0] pair;
		if (known) begin
			exp_clr = en ? (cnt >= W) : 1'b1;	// idles high
			exp_fs  = en && (cnt == FB - 1);
			if (clrclk !== exp_clr)
				report_mismatch($sformatf("clrclk %b, expected %b at count %0d",
					clrclk, exp_clr, cnt));
			if (tx_load !== exp_fs)
				report_mismatch($sformatf("tx_load %b, expected %b at count %0d",
					tx_load, exp_fs, cnt));
			if (!ever_en && sdout !== 1'b0)
				report_mismatch("sdout high before the port was ever enabled");
			if (rx_due) begin
				pair = rxq.pop_front();
				if (rx_valid !== 1'b1) begin
					report_mismatch("rx_valid low one clock after the last right bit");
				end else begin
					n_rx++;
					if ({rx_left, rx_right} !== pair)
						report_mismatch($sformatf("rx pair %h/%h, expected %h/%h",
							rx_left, rx_right, pair[2*W-1:W], pair[W-1:0]));
				end
			end else if (rx_valid !== 1'b0) begin
				report_mismatch("rx_valid high with no pair sent by the codec");
			end
			if (en) begin
				// left at counts 1..16, right at 17..31 plus count 0
				if (cnt >= 1 && cnt <= W) rl = {rl[W-2:0], sdout};
				else rr = {rr[W-2:0], sdout};
				if (cnt == 0 && txq.size() >= 2) begin	// oldest pair just ended
					pair = txq.pop_front();
					n_tx++;
					if ({rl, rr} !== pair)
						report_mismatch($sformatf("sdout pair %h/%h, expected %h/%h",
							rl, rr, pair[2*W-1:W], pair[W-1:0]));
				end
				if (exp_fs) txq.push_back(psel ? {pat_l, pat_r} : {tx_left, tx_right});
			end else begin
				txq.delete();
			end
			rx_due = codec_push;
			if (codec_push) rxq.push_back({codec_left, codec_right});
		end
		if (!rst_n) begin
			known   = 1'b1;
			ever_en = 1'b0;
			en      = 1'b0;
			psel    = 1'b0;
			pat_l   = `I2S_DEF_PATTERN;
			pat_r   = `I2S_DEF_PATTERN;
			cnt     = 0;
			rx_due  = 1'b0;
			txq.delete();
			rxq.delete();
		end else if (known) begin
			ever_en = ever_en | en;
			cnt = (!en || cnt == FB - 1) ? 0 : cnt + 1;	// from the enable now in force
			if (cfg_we) begin
				case (cfg_addr)
					REG_CTRL: begin
						en   = cfg_wdata[0];
						psel = cfg_wdata[1];
					end
					REG_PAT_L: pat_l = cfg_wdata;
					REG_PAT_R: pat_r = cfg_wdata;
					default: ;
				endcase
			end
		end
	end

endmodule

// File: tb_i2s_port.sv
/* testbench top: clock, reset, xorshift host samples, codec ADC model, run control */

`timescale 1ns/1ns
`include "i2s_consts.svh"

module tb_i2s_port;
	import i2s_pkg::*;

	localparam int W      = `I2S_WORD_BITS;
	localparam int FB     = `I2S_FRAME_BITS;
	localparam int FRAMES = 40;
	localparam int LIMIT  = (FRAMES + 10) * FB;	// cycles before the run is cut off

	logic         CBCLK = 1'b0;
	logic         rst_n, cfg_we, sdin;
	reg_addr_t    cfg_addr;
	logic [W-1:0] cfg_wdata, tx_left, tx_right;
	logic         clrclk, sdout, tx_load, rx_valid;
	logic [W-1:0] rx_left, rx_right;
	logic         codec_push;
	logic [W-1:0] codec_left, codec_right;
	int           mism_cnt, tx_words, rx_pairs;

	logic [31:0]  rng;
	logic         port_en;		// enable register as the host wrote it
	logic         load_seen;
	logic         prev_clr, armed, active;	// codec view of CLRCLK
	logic [W-1:0] cl, cr;
	logic [2*W-1:0] shw;		// codec output word, MSB goes first
	int           cycles = 0;
	int           other_errs = 0;

	i2s_port dut0 (.*);

	tb_i2s_checker chk0 (.*);

	always #10 CBCLK = ~CBCLK;	// 20 ns bit clock

	always @(posedge CBCLK) begin
		cycles++;
		if (cycles >= LIMIT) begin
			$display("Timeout: the run was still going after %0d clock cycles", LIMIT);
			$display("Test FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic next_word(output logic [W-1:0] w);
		rng = xorshift32(rng);
		w = rng[W-1:0];
	endtask

	// codec ADC side, one bit after each CLRCLK edge
	task automatic codec_step();
		if (!port_en) begin
			armed    = 1'b0;
			active   = 1'b0;
			sdin     = 1'b0;
			prev_clr = 1'b1;
		end else begin
			if (clrclk && !prev_clr) armed = 1'b1;	// rx waits for a high phase too
			if (!clrclk && prev_clr) begin
				sdin = active ? shw[2*W-1] : 1'b0;	// old right LSB in the delay slot
				if (active) begin
					codec_push  = 1'b1;
					codec_left  = cl;
					codec_right = cr;
				end
				active = armed;
				if (armed) begin
					next_word(cl);
					next_word(cr);
					shw = {cl, cr};
				end
			end else if (active) begin
				sdin = shw[2*W-1];
				shw  = shw << 1;
			end else begin
				sdin = 1'b0;
			end
			prev_clr = clrclk;
		end
	endtask

	// fresh samples once the port has taken the last pair
	task automatic host_step();
		if (load_seen) begin
			next_word(tx_left);
			next_word(tx_right);
		end
		load_seen = tx_load;
	endtask

	// one bit clock, inputs change 2 ns after the edge
	task automatic tick();
		@(posedge CBCLK);
		#2;
		if (cfg_we && cfg_addr == REG_CTRL) port_en = cfg_wdata[0];
		cfg_we     = 1'b0;
		codec_push = 1'b0;
		codec_step();
		host_step();
	endtask

	task automatic run_cycles(input int n);
		repeat (n) tick();
	endtask

	task automatic write_reg(input reg_addr_t addr, input logic [W-1:0] data);
		tick();
		cfg_we    = 1'b1;
		cfg_addr  = addr;
		cfg_wdata = data;
	endtask

	initial begin
		logic [W-1:0] pl;
		logic [W-1:0] pr;
		rst_n = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = REG_CTRL;
		cfg_wdata = '0;
		tx_left = '0;
		tx_right = '0;
		sdin = 1'b0;
		codec_push = 1'b0;
		codec_left = '0;
		codec_right = '0;
		rng = 32'h1096_c1b2;
		port_en = 1'b0;
		load_seen = 1'b0;
		prev_clr = 1'b1;
		armed = 1'b0;
		active = 1'b0;
		shw = '0;
		cl = '0;
		cr = '0;
		repeat (3) tick();
		rst_n = 1'b1;
		run_cycles(10);			// port idle, enable still 0
		next_word(tx_left);
		next_word(tx_right);
		write_reg(REG_CTRL, 16'h0001);
		run_cycles(12 * FB);
		write_reg(REG_CTRL, 16'h0003);	// pattern source with reset words
		run_cycles(3 * FB);
		next_word(pl);
		next_word(pr);
		write_reg(REG_PAT_L, pl);
		write_reg(REG_PAT_R, pr);
		run_cycles(6 * FB);
		write_reg(REG_CTRL, 16'h0001);
		run_cycles(6 * FB + 7);		// lands the stop mid-frame
		write_reg(REG_CTRL, 16'h0000);
		run_cycles(40);
		write_reg(REG_CTRL, 16'h0001);	// clean restart
		run_cycles(12 * FB + 4);
		if (tx_words < 25) begin
			other_errs++;
			$display("Too few sdout words were compared: %0d", tx_words);
		end
		if (rx_pairs < 25) begin
			other_errs++;
			$display("Too few rx pairs were compared: %0d", rx_pairs);
		end
		$display("Errors: %0d mismatches, %0d other (%0d sdout words, %0d rx pairs checked)",
			mism_cnt, other_errs, tx_words, rx_pairs);
		if (mism_cnt == 0 && other_errs == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule
